/* sim.f */
source/icachePkg.sv
source/cacheWay.sv
source/lruTable.sv
source/icacheDatapath.sv
source/icacheController.sv
source/instrCache.sv
bench/instrMemModel.sv
bench/icacheTb.sv

/* run.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module icacheTb -f sim.f -o icacheSim || exit 1
./obj_dir/icacheSim | tee /dev/stderr | grep -qx "test passed" \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation reported failure"; exit 1; }

/* bench/icacheTb.sv */
// Instruction cache testbench with stimulus table, fetch driver and checks
module icacheTb;
  timeunit 1ns;
  timeprecision 100ps;

  // Fetch address, expected hit, cycles to keep fetchReq high after fetchAck
  typedef struct packed {
    icachePkg::addrT addr;
    logic expectHit;
    logic [3:0] holdCycles;
  } fetchEntryT;

  localparam int numEntries = 13;
  localparam int ackTimeout = 200;

  localparam fetchEntryT stimTable [numEntries] = '{
    // Cold miss in set 3, then the rest of the line hits
    {32'h0000_1030, 1'b0, 4'd0},
    {32'h0000_1034, 1'b1, 4'd2},
    {32'h0000_1038, 1'b1, 4'd0},
    {32'h0000_103C, 1'b1, 4'd5},
    // Second tag goes to the empty way, both stay resident
    {32'h0000_2030, 1'b0, 4'd0},
    {32'h0000_2034, 1'b1, 4'd1},
    {32'h0000_1038, 1'b1, 4'd0},
    // Third tag replaces tag 0x20 as the least recently used
    {32'h0000_3030, 1'b0, 4'd0},
    {32'h0000_1030, 1'b1, 4'd0},
    {32'h0000_2034, 1'b0, 4'd3},
    // Untouched set starts empty
    {32'hABCD_E0F8, 1'b0, 4'd0},
    {32'hABCD_E0F4, 1'b1, 4'd2},
    {32'h0000_2038, 1'b1, 4'd0}
  };

  logic clk;
  logic reset;
  logic fetchReq;
  icachePkg::addrT fetchAddr;
  logic fetchAck;
  icachePkg::instrT fetchInstr;
  logic memReq;
  icachePkg::addrT memAddr;
  logic memAck;
  icachePkg::instrT memData;

  int mismatchCount;
  int errorCount;
  bit timedOut;
  // Word addresses of the memory handshakes seen during the current fetch
  icachePkg::addrT memWords [$];

  instrCache instrCache_i (
    .clk       (clk),
    .reset     (reset),
    .fetchReq  (fetchReq),
    .fetchAddr (fetchAddr),
    .fetchAck  (fetchAck),
    .fetchInstr(fetchInstr),
    .memReq    (memReq),
    .memAddr   (memAddr),
    .memAck    (memAck),
    .memData   (memData)
  );

  instrMemModel memModel_i (
    .clk    (clk),
    .reset  (reset),
    .memReq (memReq),
    .memAddr(memAddr),
    .memAck (memAck),
    .memData(memData)
  );

  always #2 clk = ~clk;

  // One entry per completed word, req and ack both high at the edge
  always @(posedge clk) begin
    if (!reset && memReq && memAck) begin
      memWords.push_back(memAddr);
    end
  end

  function automatic icachePkg::instrT expectedWord(input icachePkg::addrT wordAddr);
    logic [31:0] mixed;
    mixed = wordAddr * 32'h9E37_79B1;
    return mixed ^ {mixed[15:0], mixed[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  task automatic waitForAck(input logic level, output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < ackTimeout) begin
      @(negedge clk);
      cycles++;
      if (fetchAck === level) begin
        ok = 1'b1;
      end
    end
  endtask

  // Hit means no refill, miss means the whole line from word 0
  task automatic checkMemWords(input fetchEntryT entry, input int idx);
    icachePkg::addrT lineBase;
    int expectedCount;
    lineBase = {2'b00, entry.addr[31:4], 2'b00};
    expectedCount = entry.expectHit ? 0 : icachePkg::wordsPerLine;
    if (memWords.size() != expectedCount) begin
      mismatchCount++;
      $display("mismatch memReq handshakes (entry %0d): got %h, expected %h",
               idx, memWords.size(), expectedCount);
    end else begin
      foreach (memWords[k]) begin
        if (memWords[k] !== lineBase + k) begin
          mismatchCount++;
          $display("mismatch memAddr (entry %0d, word %0d): got %h, expected %h",
                   idx, k, memWords[k], lineBase + k);
        end
      end
    end
  endtask

  task automatic runFetch(input fetchEntryT entry, input int idx);
    icachePkg::instrT expected;
    bit ok;
    expected = expectedWord(entry.addr >> 2);
    memWords.delete();
    fetchAddr = entry.addr;
    fetchReq = 1'b1;
    waitForAck(1'b1, ok);
    if (!ok) begin
      errorCount++;
      timedOut = 1'b1;
      $display("entry %0d: fetchAck never rose after the request", idx);
      return;
    end
    if (fetchInstr !== expected) begin
      mismatchCount++;
      $display("mismatch fetchInstr (entry %0d, addr %h): got %h, expected %h",
               idx, entry.addr, fetchInstr, expected);
    end
    // Held request keeps the answer up and the memory port quiet
    for (int h = 0; h < int'(entry.holdCycles); h++) begin
      @(negedge clk);
      if (fetchAck !== 1'b1) begin
        mismatchCount++;
        $display("mismatch fetchAck (entry %0d): got %h, expected 1", idx, fetchAck);
      end
      if (fetchInstr !== expected) begin
        mismatchCount++;
        $display("mismatch fetchInstr (entry %0d, held): got %h, expected %h",
                 idx, fetchInstr, expected);
      end
      if (memReq !== 1'b0) begin
        mismatchCount++;
        $display("mismatch memReq (entry %0d, held): got %h, expected 0", idx, memReq);
      end
    end
    fetchReq = 1'b0;
    waitForAck(1'b0, ok);
    if (!ok) begin
      errorCount++;
      timedOut = 1'b1;
      $display("entry %0d: fetchAck stayed high after the request dropped", idx);
      return;
    end
    checkMemWords(entry, idx);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    fetchReq = 1'b0;
    fetchAddr = '0;
    mismatchCount = 0;
    errorCount = 0;
    timedOut = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    if (fetchAck !== 1'b0) begin
      mismatchCount++;
      $display("mismatch fetchAck after reset: got %h, expected 0", fetchAck);
    end
    if (memReq !== 1'b0) begin
      mismatchCount++;
      $display("mismatch memReq after reset: got %h, expected 0", memReq);
    end
    for (int i = 0; i < numEntries; i++) begin
      if (!timedOut) begin
        @(negedge clk);
        runFetch(stimTable[i], i);
      end
    end
    $display("errors: %0d mismatches, %0d other failures", mismatchCount, errorCount);
    if (mismatchCount == 0 && errorCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* bench/instrMemModel.sv */
// Memory responder for the cache refill port with random ack delays
module instrMemModel (
  input  logic clk,
  input  logic reset,
  input  logic memReq,
  input  icachePkg::addrT memAddr,
  output logic memAck,
  output icachePkg::instrT memData
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] seed = 32'd26114;

  logic [31:0] rngState;
  logic [2:0] delayLeft;
  logic ackReg = 1'b0;
  icachePkg::instrT dataReg = '0;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Memory contents are a fixed mix of the word address
  function automatic icachePkg::instrT wordValue(input icachePkg::addrT wordAddr);
    logic [31:0] mixed;
    mixed = wordAddr * 32'h9E37_79B1;
    return mixed ^ {mixed[15:0], mixed[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  // Outputs move on the falling edge, half a cycle away from the cache
  always @(negedge clk) begin
    if (reset) begin
      ackReg <= 1'b0;
      dataReg <= '0;
      rngState <= xorshift(seed);
      delayLeft <= 3'(xorshift(seed) % 32'd6);
    end else if (!ackReg) begin
      // Delay only runs down while a word is requested
      if (memReq && delayLeft == 3'd0) begin
        ackReg <= 1'b1;
        dataReg <= wordValue(memAddr);
      end else if (memReq) begin
        delayLeft <= delayLeft - 3'd1;
      end
    end else if (!memReq) begin
      ackReg <= 1'b0;
      rngState <= xorshift(rngState);
      delayLeft <= 3'(xorshift(rngState) % 32'd6);
    end
  end

  assign memAck = ackReg;
  assign memData = dataReg;

endmodule

/* source/instrCache.sv */
// Two-way instruction cache top with controller and datapath
module instrCache (
  input  logic clk,
  input  logic reset,
  // CPU fetch port
  input  logic fetchReq,
  input  icachePkg::addrT fetchAddr,
  output logic fetchAck,
  output icachePkg::instrT fetchInstr,
  // Memory refill port
  output logic memReq,
  output icachePkg::addrT memAddr,
  input  logic memAck,
  input  icachePkg::instrT memData
);

  icachePkg::wayStatusT way0Status;
  icachePkg::wayStatusT way1Status;
  icachePkg::fillWriteT fill;
  logic fillLine;
  logic touch;

  icacheController ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .fetchReq  (fetchReq),
    .fetchAddr (fetchAddr),
    .way0Status(way0Status),
    .way1Status(way1Status),
    .fetchAck  (fetchAck),
    .memReq    (memReq),
    .memAddr   (memAddr),
    .memAck    (memAck),
    .memData   (memData),
    .fill      (fill),
    .fillLine  (fillLine),
    .touch     (touch)
  );

  icacheDatapath dpath_i (
    .clk       (clk),
    .reset     (reset),
    .fetchAddr (fetchAddr),
    .fill      (fill),
    .fillLine  (fillLine),
    .touch     (touch),
    .way0Status(way0Status),
    .way1Status(way1Status),
    .fetchInstr(fetchInstr)
  );

endmodule

/* source/icacheController.sv */
// Cache controller FSM with fill word counter, fetch and memory handshakes
module icacheController (
  input  logic clk,
  input  logic reset,
  input  logic fetchReq,
  input  icachePkg::addrT fetchAddr,
  input  icachePkg::wayStatusT way0Status,
  input  icachePkg::wayStatusT way1Status,
  output logic fetchAck,
  output logic memReq,
  output icachePkg::addrT memAddr,
  input  logic memAck,
  input  icachePkg::instrT memData,
  output icachePkg::fillWriteT fill,
  output logic fillLine,
  output logic touch
);

  icachePkg::ctrlStateT state;
  icachePkg::ctrlStateT nextState;

  icachePkg::wordOffT fillCount;
  icachePkg::addrT wordAddr;

  logic hit;
  logic wordDone;
  logic lastWord;

  assign hit = way0Status.hit || way1Status.hit;

  // A memory word completes while both req and ack are high
  assign wordDone = (state == icachePkg::memRead) && memReq && memAck;
  assign lastWord = wordDone && (fillCount == 2'd3);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= icachePkg::idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      icachePkg::idle: begin
        if (fetchReq) begin
          nextState = hit ? icachePkg::respond : icachePkg::memRead;
        end
      end
      icachePkg::memRead: begin
        if (lastWord) begin
          nextState = icachePkg::nextInstr;
        end
      end
      icachePkg::nextInstr: begin
        nextState = icachePkg::respond;
      end
      icachePkg::respond: begin
        // Stay here while the CPU holds its request
        if (!fetchReq) begin
          nextState = icachePkg::idle;
        end
      end
      default: begin
        nextState = icachePkg::idle;
      end
    endcase
  end

  // Word counter for the sequential line refill
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      fillCount <= '0;
    end else if (state == icachePkg::idle || state == icachePkg::nextInstr) begin
      fillCount <= '0;
    end else if (wordDone) begin
      fillCount <= fillCount + 2'd1;
    end
  end

  // Memory request drops on ack and waits for ack low before the next word
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      memReq <= 1'b0;
    end else if (wordDone) begin
      memReq <= 1'b0;
    end else if (state == icachePkg::memRead && !memReq && !memAck) begin
      memReq <= 1'b1;
    end
  end

  // Fetch ack rises on leaving nextInstr or one cycle into a hit
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      fetchAck <= 1'b0;
    end else begin
      fetchAck <= (state == icachePkg::nextInstr) ||
                  (state == icachePkg::respond && fetchReq);
    end
  end

  // Word address of the current refill word
  assign wordAddr = fetchAddr >> icachePkg::byteOffBits;
  assign memAddr = {wordAddr[31:2], fillCount};

  always_comb begin
    fill.writeEn = wordDone;
    fill.wordOff = fillCount;
    fill.data = memData;
  end

  // Victim is chosen and the new tag installed as the miss is taken
  assign fillLine = (state == icachePkg::idle) && fetchReq && !hit;

  // LRU update on every entry into respond
  assign touch = ((state == icachePkg::idle) && fetchReq && hit) ||
                 (state == icachePkg::nextInstr);

  assert property (@(posedge clk) disable iff (reset)
    fetchAck |-> $past(fetchReq))
    else $error("icacheController: fetchAck high without fetchReq");

endmodule

/* source/icacheDatapath.sv */
// Cache datapath with two ways, LRU table, victim choice and instruction select
module icacheDatapath (
  input  logic clk,
  input  logic reset,
  input  icachePkg::addrT fetchAddr,
  input  icachePkg::fillWriteT fill,
  input  logic fillLine,
  input  logic touch,
  output icachePkg::wayStatusT way0Status,
  output icachePkg::wayStatusT way1Status,
  output icachePkg::instrT fetchInstr
);

  // Address fields
  icachePkg::tagT addrTag;
  icachePkg::indexT addrIndex;
  icachePkg::wordOffT addrWord;

  icachePkg::instrT way0Instr;
  icachePkg::instrT way1Instr;

  logic lruWay;
  logic victimNow;
  logic victimReg;
  logic fillWay;

  assign addrTag = fetchAddr[31:8];
  assign addrIndex = fetchAddr[7:4];
  assign addrWord = fetchAddr[3:2];

  // Victim rule: hit way, then the single invalid way, then LRU
  always_comb begin
    if (way0Status.hit || way1Status.hit) begin
      victimNow = way1Status.hit;
    end else if (way0Status.valid != way1Status.valid) begin
      // way 0 valid means way 1 is the empty one
      victimNow = way0Status.valid;
    end else begin
      victimNow = lruWay;
    end
  end

  // Hold the choice for the rest of the line, since the new tag
  // changes the lookup as soon as it is installed
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      victimReg <= 1'b0;
    end else if (fillLine) begin
      victimReg <= victimNow;
    end
  end

  assign fillWay = fillLine ? victimNow : victimReg;

  cacheWay way0_i (
    .clk        (clk),
    .reset      (reset),
    .lookupIndex(addrIndex),
    .lookupTag  (addrTag),
    .lookupWord (addrWord),
    .fill       (fill),
    .fillLine   (fillLine),
    .selected   (~fillWay),
    .status     (way0Status),
    .readInstr  (way0Instr)
  );

  cacheWay way1_i (
    .clk        (clk),
    .reset      (reset),
    .lookupIndex(addrIndex),
    .lookupTag  (addrTag),
    .lookupWord (addrWord),
    .fill       (fill),
    .fillLine   (fillLine),
    .selected   (fillWay),
    .status     (way1Status),
    .readInstr  (way1Instr)
  );

  // The answering way becomes most recently used
  lruTable lru_i (
    .clk    (clk),
    .reset  (reset),
    .index  (addrIndex),
    .touch  (touch),
    .usedWay(way1Status.hit),
    .lru    (lruWay)
  );

  assign fetchInstr = way1Status.hit ? way1Instr : way0Instr;

  // A tag lives in at most one way of a set
  assert property (@(posedge clk) disable iff (reset)
    !(way0Status.hit && way1Status.hit))
    else $error("icacheDatapath: both ways hit the same address");

endmodule

/* source/lruTable.sv */
// LRU bit per set for the two-way cache, pointing at the way to replace
module lruTable (
  input  logic clk,
  input  logic reset,
  input  icachePkg::indexT index,
  input  logic touch,
  input  logic usedWay,
  output logic lru
);

  // One bit per set; zero means way 0 is next to go
  logic [icachePkg::numSets-1:0] lruBits;

  // Each answered fetch marks its way as most recently used
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (touch) begin
      lruBits[index] <= ~usedWay;
    end
  end

  // Current replacement candidate for the addressed set
  assign lru = lruBits[index];

endmodule

/* source/cacheWay.sv */
// One cache way with tag, valid and word arrays, tag compare and refill write
module cacheWay (
  input  logic clk,
  input  logic reset,
  input  icachePkg::indexT lookupIndex,
  input  icachePkg::tagT lookupTag,
  input  icachePkg::wordOffT lookupWord,
  input  icachePkg::fillWriteT fill,
  input  logic fillLine,
  input  logic selected,
  output icachePkg::wayStatusT status,
  output icachePkg::instrT readInstr
);

  // Storage per set
  icachePkg::tagT tags [icachePkg::numSets];
  icachePkg::instrT words [icachePkg::numSets][icachePkg::wordsPerLine];
  logic [icachePkg::numSets-1:0] validBits;

  logic tagWrite;
  logic wordWrite;
  logic setValid;
  logic tagMatch;

  // Only the victim way takes the new line
  assign tagWrite = fillLine && selected;
  assign wordWrite = fill.writeEn && selected;

  // Valid bits are control state and start cleared
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '0;
    end else if (tagWrite) begin
      validBits[lookupIndex] <= 1'b1;
    end
  end

  // Tag is installed at the start of the refill
  always_ff @(posedge clk) begin
    if (tagWrite) begin
      tags[lookupIndex] <= lookupTag;
    end
  end

  // Refill words arrive one at a time, in order from word 0
  always_ff @(posedge clk) begin
    if (wordWrite) begin
      words[lookupIndex][fill.wordOff] <= fill.data;
    end
  end

  // Lookup of the addressed set
  assign setValid = validBits[lookupIndex];
  assign tagMatch = (tags[lookupIndex] == lookupTag);

  always_comb begin
    status.valid = setValid;
    status.hit = setValid && tagMatch;
  end

  assign readInstr = words[lookupIndex][lookupWord];

  // A refill word only lands in a line whose tag this way took on fillLine
  assert property (@(posedge clk) disable iff (reset)
    wordWrite |-> (setValid && tagMatch))
    else $error("cacheWay: fill word written to a line not installed in this way");

endmodule

/* source/icachePkg.sv */
// Instruction cache widths, address field types, datapath structs and FSM states
package icachePkg;

  // Line geometry
  localparam int wordBytes = 4;
  localparam int wordsPerLine = 4;
  localparam int numSets = 16;

  // Byte offset bits inside one word, used to form word addresses
  localparam int byteOffBits = $clog2(wordBytes);

  // Byte address on the fetch port, word address on the memory port
  typedef logic [31:0] addrT;

  typedef logic [31:0] instrT;

  // Address fields: tag 31..8, index 7..4, word offset 3..2
  typedef logic [23:0] tagT;
  typedef logic [3:0] indexT;
  typedef logic [1:0] wordOffT;

  // Lookup result of one way for the addressed set
  typedef struct packed {
    logic hit;
    logic valid;
  } wayStatusT;

  // One refill word on its way from the memory port into the arrays
  typedef struct packed {
    logic writeEn;
    wordOffT wordOff;
    instrT data;
  } fillWriteT;

  // Controller states
  typedef enum logic [1:0] {
    idle,
    memRead,
    nextInstr,
    respond
  } ctrlStateT;

endpackage
